// File: hdl/tm1637_pkg.sv
// Shared widths, step word encodings and debug LED mode codes.
`default_nettype none

package tm1637_pkg;

    localparam int STEP_WIDTH   = 48;  // One encoded step.
    localparam int ADDR_WIDTH   = 4;   // Step index, 16 steps.
    localparam int BYTE_WIDTH   = 8;   // Byte sent on the DIO link.
    localparam int REPEAT_WIDTH = 15;  // Repeat count, split across two fields.
    localparam int LED_WIDTH    = 4;   // Board LEDs and switches.

    // Normalised switch codes. Any other code shows the switches.
    localparam logic [LED_WIDTH-1:0] LED_MODE_STEP  = 4'b0001;  // Current step index.
    localparam logic [LED_WIDTH-1:0] LED_MODE_HEART = 4'b0100;  // Heartbeat level.
    localparam logic [LED_WIDTH-1:0] LED_MODE_PINS  = 4'b0101;  // Clock and data pins.
    localparam logic [LED_WIDTH-1:0] LED_MODE_WAIT  = 4'b0110;  // Sequencer waiting.

    // Ordinary step: optional byte write and optional wait for completion.
    typedef struct packed {
        logic                  backward;       // Jump goes backward.
        logic [2:0]            next;           // Jump offset, 0 halts.
        logic [27:0]           rsvd_time;      // Unused start-time field.
        logic [BYTE_WIDTH-1:0] tx_data;        // Byte to send.
        logic                  should_repeat;  // Clear for this view.
        logic [3:0]            rsvd_pins;
        logic                  wr;             // Send tx_data.
        logic                  rsvd_rd;
        logic                  wait_done;      // Hold until the byte is out.
    } step_cmd_t;

    // Repeat step: loads the loop counter.
    typedef struct packed {
        logic        backward;
        logic [2:0]  next;
        logic [27:0] rsvd_time;
        logic [7:0]  repeat_lo;      // Low count bits, shares tx_data bits.
        logic        should_repeat;  // Set for this view.
        logic [6:0]  repeat_hi;      // High count bits.
    } step_rep_t;

    // Same 48 bits read two ways, told apart by should_repeat.
    typedef union packed {
        step_cmd_t cmd;
        step_rep_t rep;
    } step_word_t;

endpackage

`default_nettype wire

// File: hdl/tick_divider.sv
// Tick divider producing a one-cycle tick enable and a heartbeat level.
`timescale 1ns/10ps
`default_nettype none

module tick_divider #(
    parameter int DIV_COUNT = 25_000_000  // clk_50M cycles per tick.
) (
    input  wire  clk_50M,
    input  wire  rst_n,
    output logic tick,   // One-cycle pulse.
    output logic heart   // Flips on every tick.
);

    localparam int CW = (DIV_COUNT > 1) ? $clog2(DIV_COUNT) : 1;

    logic [CW-1:0] cnt;  // Cycles since last tick.

    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            cnt   <= '0;
            tick  <= 1'b0;
            heart <= 1'b0;
        end else if (cnt == CW'(DIV_COUNT - 1)) begin
            cnt   <= '0;      // Reload.
            tick  <= 1'b1;
            heart <= ~heart;
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/step_rom.sv
// Combinational step ROM holding the display initialisation program.
`timescale 1ns/10ps
`default_nettype none

module step_rom (
    input  wire [tm1637_pkg::ADDR_WIDTH-1:0] step_id,
    output tm1637_pkg::step_word_t           step
);

    // Ordinary step that writes one byte.
    function automatic tm1637_pkg::step_word_t write_step(
        input logic [7:0] data,
        input logic       wait_done,
        input logic       backward,
        input logic [2:0] next
    );
        tm1637_pkg::step_word_t w;
        w               = '0;
        w.cmd.backward  = backward;
        w.cmd.next      = next;
        w.cmd.tx_data   = data;
        w.cmd.wr        = 1'b1;
        w.cmd.wait_done = wait_done;
        return w;
    endfunction

    // Repeat step that loads the loop counter and moves on.
    function automatic tm1637_pkg::step_word_t repeat_step(
        input logic [tm1637_pkg::REPEAT_WIDTH-1:0] count
    );
        tm1637_pkg::step_word_t w;
        w                   = '0;
        w.rep.next          = 3'd1;
        w.rep.should_repeat = 1'b1;
        w.rep.repeat_lo     = count[7:0];
        w.rep.repeat_hi     = count[14:8];
        return w;
    endfunction

    always_comb begin
        case (step_id)
            4'd0:    step = write_step(8'h40, 1'b1, 1'b0, 3'd1);  // Data command, auto increment.
            4'd1:    step = repeat_step(15'd2);                   // Loop the next pair twice more.
            4'd2:    step = write_step(8'hC0, 1'b1, 1'b0, 3'd1);  // Address command, digit 0.
            4'd3:    step = write_step(8'h3F, 1'b1, 1'b1, 3'd1);  // Segments for "0", loop back.
            4'd4:    step = write_step(8'h8F, 1'b1, 1'b0, 3'd1);  // Display on, full brightness.
            default: step = '0;                                   // Step 5 and spares halt.
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/step_sequencer.sv
// Two-phase step sequencer with repeat counting, backward jumps and halt.
`timescale 1ns/10ps
`default_nettype none

module step_sequencer (
    input  wire                                  clk_50M,
    input  wire                                  rst_n,
    input  wire                                  tick,      // Step enable.
    input  tm1637_pkg::step_word_t               step,      // ROM word for step_id.
    input  wire                                  tx_done,   // Byte finished.
    input  wire                                  tx_busy,   // Serializer in use.
    output logic [tm1637_pkg::ADDR_WIDTH-1:0]    step_id,
    output logic                                 tx_start,  // Start pulse on a tick.
    output logic [tm1637_pkg::BYTE_WIDTH-1:0]    tx_byte,
    output logic                                 waiting    // Phase 1 holding for tx_done.
);

    localparam int AW = tm1637_pkg::ADDR_WIDTH;
    localparam int RW = tm1637_pkg::REPEAT_WIDTH;

    logic          phase;         // 0 sets up the step, 1 finishes it.
    logic          wait_q;        // Latched wait_done.
    logic          done_seen;     // tx_done arrived during phase 1.
    logic [AW-1:0] next_id;       // Index to load when phase 1 ends.
    logic [RW-1:0] repeat_count;  // Remaining backward jumps.

    // Decoded view of the current word.
    logic is_rep;
    logic is_halt;
    logic is_write;
    logic do_jump;

    assign is_rep   = step.cmd.should_repeat;                        // Same bit in both views.
    assign is_halt  = !is_rep && !step.cmd.backward && (step.cmd.next == 3'd0);
    assign is_write = !is_rep && !is_halt && step.cmd.wr;
    assign do_jump  = !is_rep && step.cmd.backward && (repeat_count != '0);

    // Start only on a tick with the serializer free.
    assign tx_start = tick && !phase && is_write && !tx_busy;
    assign tx_byte  = step.cmd.tx_data;                              // Sampled with tx_start.
    assign waiting  = phase && wait_q && !done_seen;

    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            phase        <= 1'b0;
            wait_q       <= 1'b0;
            done_seen    <= 1'b0;
            next_id      <= '0;
            repeat_count <= '0;
            step_id      <= '0;
        end else if (!phase) begin
            // Halt holds here, a busy serializer stalls the write.
            if (tick && !is_halt && !(is_write && tx_busy)) begin
                phase     <= 1'b1;
                wait_q    <= !is_rep && step.cmd.wait_done;
                done_seen <= 1'b0;
                if (is_rep) begin
                    repeat_count <= {step.rep.repeat_hi, step.rep.repeat_lo};
                    next_id      <= step_id + 1'b1;
                end else if (do_jump) begin
                    repeat_count <= repeat_count - 1'b1;               // One pass used.
                    next_id      <= step_id - AW'(step.cmd.next);
                end else begin
                    next_id <= step_id + 1'b1;
                end
            end
        end else begin
            if (tick && (!wait_q || done_seen)) begin
                phase     <= 1'b0;
                done_seen <= 1'b0;
                step_id   <= next_id;  // New word appears from the ROM.
            end else if (tx_done) begin
                done_seen <= 1'b1;     // Kept until the next tick.
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/dio_serializer.sv
// Prescaled LSB-first byte transmitter driving the TM1637 clock and data lines.
`timescale 1ns/10ps
`default_nettype none

module dio_serializer #(
    parameter int PRESCALE = 2  // Ticks per half bit.
) (
    input  wire                                clk_50M,
    input  wire                                rst_n,
    input  wire                                tick,
    input  wire                                tx_start,  // Load tx_byte.
    input  wire  [tm1637_pkg::BYTE_WIDTH-1:0]  tx_byte,
    output logic                               tx_busy,
    output logic                               tx_done,   // Last high phase ended.
    output logic                               tm1637_clk,
    output logic                               tm1637_dio
);

    localparam int PW = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;
    localparam int BW = tm1637_pkg::BYTE_WIDTH;

    logic [BW-1:0] shift_q;    // Bits not yet sent, current at [0].
    logic [PW-1:0] presc_cnt;  // Ticks into the half bit.
    logic [2:0]    bit_cnt;    // Bit being sent.
    logic          half_end;

    assign half_end = (presc_cnt == PW'(PRESCALE - 1));

    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            tx_busy    <= 1'b0;
            tx_done    <= 1'b0;
            tm1637_clk <= 1'b1;  // Idle high.
            tm1637_dio <= 1'b1;
            presc_cnt  <= '0;
            bit_cnt    <= '0;
        end else begin
            tx_done <= 1'b0;
            if (tick) begin
                if (!tx_busy) begin
                    if (tx_start) begin
                        tx_busy    <= 1'b1;
                        tm1637_clk <= 1'b0;        // Falling edge launches bit 0.
                        tm1637_dio <= tx_byte[0];
                        presc_cnt  <= '0;
                        bit_cnt    <= '0;
                    end
                end else if (!half_end) begin
                    presc_cnt <= presc_cnt + 1'b1;
                end else begin
                    presc_cnt <= '0;
                    if (!tm1637_clk) begin
                        tm1637_clk <= 1'b1;        // Receiver samples here.
                    end else if (bit_cnt == 3'd7) begin
                        tx_busy    <= 1'b0;        // Clock stays high.
                        tx_done    <= 1'b1;
                        tm1637_dio <= 1'b1;
                    end else begin
                        bit_cnt    <= bit_cnt + 1'b1;
                        tm1637_clk <= 1'b0;
                        tm1637_dio <= shift_q[1];  // Next bit while clock is low.
                    end
                end
            end
        end
    end

    // Payload shifter, no reset.
    always_ff @(posedge clk_50M) begin
        if (tick && !tx_busy && tx_start) begin
            shift_q <= tx_byte;
        end else if (tick && tx_busy && half_end && tm1637_clk) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/debug_led_mux.sv
// Debug LED multiplexer with switch normalisation and active-low LED drive.
`timescale 1ns/10ps
`default_nettype none

module debug_led_mux (
    input  wire                               rst_n,
    input  wire  [tm1637_pkg::LED_WIDTH-1:0]  switches,  // Inverted, SW4 at bit 0.
    input  wire  [tm1637_pkg::ADDR_WIDTH-1:0] step_id,
    input  wire                               heart,
    input  wire                               tm1637_clk,
    input  wire                               tm1637_dio,
    input  wire                               waiting,
    output logic [tm1637_pkg::LED_WIDTH-1:0]  led        // Active low, reversed.
);

    logic [tm1637_pkg::LED_WIDTH-1:0] norm_sw;  // Up is 1, SW4 is the MSB.
    logic [tm1637_pkg::LED_WIDTH-1:0] view;     // 1 means LED on.

    assign norm_sw = {~switches[0], ~switches[1], ~switches[2], ~switches[3]};

    always_comb begin
        case (norm_sw)
            tm1637_pkg::LED_MODE_STEP:  view = step_id;
            tm1637_pkg::LED_MODE_HEART: view = {heart, ~heart, 1'b1, 1'b0};
            tm1637_pkg::LED_MODE_PINS:  view = {tm1637_clk, ~tm1637_clk, tm1637_dio, ~tm1637_dio};
            tm1637_pkg::LED_MODE_WAIT:  view = {3'b000, waiting};
            default:                    view = norm_sw;  // Echo the switches.
        endcase
    end

    // All LEDs forced during reset. Otherwise invert and reverse for the board.
    assign led = (!rst_n) ? '1 : {~view[0], ~view[1], ~view[2], ~view[3]};

endmodule

`default_nettype wire

// File: hdl/tm1637_demo.sv
// Top level of the TM1637 initialiser with divider, ROM, sequencer, serializer and LED mux.
`timescale 1ns/10ps
`default_nettype none

module tm1637_demo #(
    parameter int DIV_COUNT = 25_000_000,  // One tick per half second.
    parameter int PRESCALE  = 2            // Ticks per half bit.
) (
    input  wire                               clk_50M,
    input  wire                               rst_n,
    input  wire  [tm1637_pkg::LED_WIDTH-1:0]  switches,
    output wire                               tm1637_clk,
    output wire                               tm1637_dio,
    output wire  [tm1637_pkg::LED_WIDTH-1:0]  led
);

    wire                                tick;
    wire                                heart;
    wire [tm1637_pkg::ADDR_WIDTH-1:0]   step_id;
    tm1637_pkg::step_word_t             step;
    wire                                tx_start;
    wire [tm1637_pkg::BYTE_WIDTH-1:0]   tx_byte;
    wire                                tx_busy;
    wire                                tx_done;
    wire                                waiting;

    tick_divider #(.DIV_COUNT(DIV_COUNT)) tick_divider_i (
        .clk_50M (clk_50M),
        .rst_n   (rst_n),
        .tick    (tick),
        .heart   (heart)
    );

    step_rom step_rom_i (
        .step_id (step_id),
        .step    (step)
    );

    step_sequencer step_sequencer_i (
        .clk_50M  (clk_50M),
        .rst_n    (rst_n),
        .tick     (tick),
        .step     (step),
        .tx_done  (tx_done),
        .tx_busy  (tx_busy),
        .step_id  (step_id),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .waiting  (waiting)
    );

    dio_serializer #(.PRESCALE(PRESCALE)) dio_serializer_i (
        .clk_50M    (clk_50M),
        .rst_n      (rst_n),
        .tick       (tick),
        .tx_start   (tx_start),
        .tx_byte    (tx_byte),
        .tx_busy    (tx_busy),
        .tx_done    (tx_done),
        .tm1637_clk (tm1637_clk),
        .tm1637_dio (tm1637_dio)
    );

    debug_led_mux debug_led_mux_i (
        .rst_n      (rst_n),
        .switches   (switches),
        .step_id    (step_id),
        .heart      (heart),
        .tm1637_clk (tm1637_clk),
        .tm1637_dio (tm1637_dio),
        .waiting    (waiting),
        .led        (led)
    );

endmodule

`default_nettype wire

// File: dv/tm1637_demo_assert.sv
// Concurrent assertions on the serializer start, done and data-stability rules, with bind.
`timescale 1ns/10ps
`default_nettype none

module tm1637_demo_assert (
    input wire clk_50M,
    input wire rst_n,
    input wire tx_start,
    input wire tx_busy,
    input wire tx_done,
    input wire tm1637_clk,
    input wire tm1637_dio
);

    // Done is a strobe.
    done_one_cycle: assert property (@(posedge clk_50M) disable iff (!rst_n)
        tx_done |=> !tx_done)
        else $error("tx_done held longer than one cycle");

    start_when_idle: assert property (@(posedge clk_50M) disable iff (!rst_n)
        !(tx_start && tx_busy))
        else $error("tx_start issued while tx_busy");

    // Receiver samples during the high phase.
    dio_stable_high: assert property (@(posedge clk_50M) disable iff (!rst_n)
        (tx_busy && tm1637_clk && $past(tx_busy && tm1637_clk)) |-> $stable(tm1637_dio))
        else $error("tm1637_dio changed while tm1637_clk high");

endmodule

bind dio_serializer tm1637_demo_assert dio_serializer_assert_i (
    .clk_50M    (clk_50M),
    .rst_n      (rst_n),
    .tx_start   (tx_start),
    .tx_busy    (tx_busy),
    .tx_done    (tx_done),
    .tm1637_clk (tm1637_clk),
    .tm1637_dio (tm1637_dio)
);

`default_nettype wire

// File: dv/tm1637_demo_tb.sv
// Testbench for tm1637_demo with clock, reset, byte capture, LFSR switch stimulus and checks.
`timescale 1ns/10ps
`default_nettype none

module tm1637_demo_tb;

    localparam int DIV_COUNT    = 3;
    localparam int PRESCALE     = 2;
    localparam int BIT_CYCLES   = 2 * PRESCALE * DIV_COUNT;  // clk_50M cycles per bit.
    localparam int BYTE_TIMEOUT = 32 * BIT_CYCLES;           // Generous, covers step overhead.
    localparam int HALT_WINDOW  = 40 * BIT_CYCLES;
    localparam int N_BYTES      = 8;
    localparam int N_LED_CASES  = 5;
    localparam int N_RANDOM     = 12;

    logic       clk_50M;
    logic       rst_n;
    logic [3:0] switches;
    wire        tm1637_clk;
    wire        tm1637_dio;
    wire  [3:0] led;

    // 40, then the C0/3F pair once plus two repeats, then 8F.
    logic [7:0] exp_bytes [N_BYTES] = '{8'h40, 8'hC0, 8'h3F, 8'hC0, 8'h3F, 8'hC0, 8'h3F, 8'h8F};

    // Raw switches and the led expected after the halt (pins, step 5, wait, two echoes).
    logic [3:0] case_sw  [N_LED_CASES] = '{4'b0101, 4'b0111, 4'b1001, 4'b1111, 4'b1110};
    logic [3:0] case_led [N_LED_CASES] = '{4'b1010, 4'b0101, 4'b1111, 4'b1111, 4'b1110};

    logic [7:0]  captured [$];  // Bytes seen on the link.
    logic [7:0]  shift_in;
    int          bit_count;
    int          fall_count;    // Falling clk edges after reset.
    int          error_count;
    int          check_count;
    int          test_count;
    bit          timed_out;
    logic [31:0] lfsr_state;

    tm1637_demo #(.DIV_COUNT(DIV_COUNT), .PRESCALE(PRESCALE)) tm1637_demo_i (
        .clk_50M    (clk_50M),
        .rst_n      (rst_n),
        .switches   (switches),
        .tm1637_clk (tm1637_clk),
        .tm1637_dio (tm1637_dio),
        .led        (led)
    );

    always #20 clk_50M = ~clk_50M;  // 40 ns period.

    // Receiver side, data is valid at the rising clk.
    always @(posedge tm1637_clk) begin
        if (rst_n === 1'b1) begin
            shift_in  = {tm1637_dio, shift_in[7:1]};  // LSB arrives first.
            bit_count = bit_count + 1;
            if (bit_count == 8) begin
                captured.push_back(shift_in);
                bit_count = 0;
            end
        end
    end

    always @(negedge tm1637_clk) begin
        if (rst_n === 1'b1) fall_count = fall_count + 1;
    end

    // Fibonacci LFSR, taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_switch_pattern(output logic [3:0] pat);
        for (int b = 0; b < 4; b++) begin
            lfsr_state = lfsr_next(lfsr_state);  // One step per bit.
            pat[b]     = lfsr_state[0];
        end
    endtask

    // Switch bits inverted, order reversed.
    function automatic logic [3:0] normalise(input logic [3:0] sw);
        logic [3:0] n;
        for (int i = 0; i < 4; i++) n[3 - i] = ~sw[i];
        return n;
    endfunction

    // Active-low board LEDs, wired in reverse.
    function automatic logic [3:0] led_drive(input logic [3:0] view);
        logic [3:0] d;
        for (int i = 0; i < 4; i++) d[3 - i] = ~view[i];
        return d;
    endfunction

    function automatic bit is_mode_code(input logic [3:0] code);
        return code inside {tm1637_pkg::LED_MODE_STEP, tm1637_pkg::LED_MODE_HEART,
                            tm1637_pkg::LED_MODE_PINS, tm1637_pkg::LED_MODE_WAIT};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (error_count == errs_before) $display("test %-14s ok", name);
        else $display("test %-14s %0d error(s)", name, error_count - errs_before);
    endtask

    task automatic wait_for_byte(input int idx, output bit ok);
        int cycles;
        cycles = 0;
        while (captured.size() <= idx && cycles < BYTE_TIMEOUT) begin
            @(negedge clk_50M);
            cycles++;
        end
        ok = (captured.size() > idx);
        if (!ok) $display("Timeout: byte %0d not received within %0d cycles", idx, BYTE_TIMEOUT);
    endtask

    task automatic run_tests();
        int         errs;
        bit         ok;
        logic [3:0] pat;
        int         falls_at_halt;

        // Reset drives every LED pin high, pins idle high before the first tick.
        errs = error_count;
        for (int c = 0; c < 10; c++) begin
            @(negedge clk_50M);
            if (c >= 2) check_value("led in reset", 32'(led), 32'hF);
        end
        rst_n = 1'b1;
        @(negedge clk_50M);
        check_value("tm1637_clk after reset", 32'(tm1637_clk), 32'h1);
        check_value("tm1637_dio after reset", 32'(tm1637_dio), 32'h1);
        report_test("reset_state", errs);

        errs = error_count;
        for (int i = 0; i < N_BYTES; i++) begin
            wait_for_byte(i, ok);
            if (!ok) begin
                timed_out = 1'b1;
                return;
            end
            check_value($sformatf("byte %0d", i), 32'(captured[i]), 32'(exp_bytes[i]));
        end
        report_test("byte_stream", errs);

        // Nothing moves on the link once step 5 is reached.
        errs          = error_count;
        falls_at_halt = fall_count;
        for (int c = 0; c < HALT_WINDOW; c++) @(negedge clk_50M);
        check_value("clk falls after halt", 32'(fall_count - falls_at_halt), 32'h0);
        check_value("bytes after halt", 32'(captured.size()), 32'(N_BYTES));
        check_value("tm1637_clk idle", 32'(tm1637_clk), 32'h1);
        check_value("tm1637_dio idle", 32'(tm1637_dio), 32'h1);
        report_test("halt", errs);

        errs = error_count;
        for (int n = 0; n < N_RANDOM; n++) begin
            draw_switch_pattern(pat);
            if (!is_mode_code(normalise(pat))) begin  // Echo view only.
                @(negedge clk_50M);
                switches = pat;
                @(negedge clk_50M);
                check_value($sformatf("led for switches %b", pat), 32'(led),
                            32'(led_drive(normalise(pat))));
            end
        end
        report_test("random_switches", errs);

        errs = error_count;
        for (int k = 0; k < N_LED_CASES; k++) begin
            @(negedge clk_50M);
            switches = case_sw[k];
            @(negedge clk_50M);
            check_value($sformatf("led case %0d", k), 32'(led), 32'(case_led[k]));
        end
        report_test("led_cases", errs);
    endtask

    initial begin
        clk_50M     = 1'b0;
        rst_n       = 1'b0;
        switches    = 4'b0000;  // Echo view gives led 0000, so the forced 1111 stands out.
        shift_in    = '0;
        bit_count   = 0;
        fall_count  = 0;
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        timed_out   = 1'b0;
        lfsr_state  = 32'hbab6;
        run_tests();
        $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (!timed_out && error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
hdl/tm1637_pkg.sv
hdl/tick_divider.sv
hdl/step_rom.sv
hdl/step_sequencer.sv
hdl/dio_serializer.sv
hdl/debug_led_mux.sv
hdl/tm1637_demo.sv
dv/tm1637_demo_assert.sv
dv/tm1637_demo_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tm1637_demo_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= Testbench passed

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
